// ==== source/soc_bus_pkg.sv ====
package soc_bus_pkg;

    // bus widths
    localparam int addr_w = 16;
    localparam int data_w = 64;
    localparam int word_w = 32;

    // ram geometry, 1 KB of 32-bit words
    localparam int ram_words = 256;
    localparam int ram_idx_w = $clog2(ram_words);

    // address map
    localparam logic [addr_w-1:0] ram_base = 16'h1000;
    localparam logic [addr_w-1:0] key_addr = 16'h2000;
    localparam logic [addr_w-1:0] art_addr = 16'h2008;

    // load/store type code from the processor
    // low two bits give the size, bit 2 marks an unsigned load
    typedef enum logic [2:0] {
        ls_b  = 3'd0,
        ls_h  = 3'd1,
        ls_w  = 3'd2,
        ls_d  = 3'd3,
        ls_bu = 3'd4,
        ls_hu = 3'd5,
        ls_wu = 3'd6
    } ls_type_e;

    // access FSM states
    typedef enum logic [1:0] {
        st_idle,
        st_low,
        st_high,
        st_finish
    } bus_state_e;

endpackage

// ==== source/bus_control.sv ====
`timescale 1ns/100ps

module bus_control
    import soc_bus_pkg::*;
(
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  logic                 read_en,
    input  logic                 write_en,
    input  logic [addr_w-1:0]    address,
    input  logic [data_w-1:0]    write_data,
    input  logic [2:0]           ls_type,
    input  logic [data_w-1:0]    ram_rdata,
    input  logic [7:0]           key_byte,
    output logic                 read_done,
    output logic                 write_done,
    output logic [data_w-1:0]    read_data,
    output logic [ram_idx_w-1:0] ram_index,
    output logic [word_w/8-1:0]  ram_lane_mask,
    output logic [word_w-1:0]    ram_wdata,
    output logic                 ram_we,
    output logic                 ram_re,
    output logic [1:0]           ram_shift,
    output ls_type_e             ram_type,
    output logic                 art_wr_strobe,
    output logic [7:0]           art_byte
);

    bus_state_e        state;
    // first or second cycle of st_finish
    logic              settled;
    // latched request and its region decoded once
    logic [addr_w-1:0] req_addr;
    logic [data_w-1:0] req_data;
    ls_type_e          req_type;
    logic              req_read;
    logic              req_ram;
    logic              req_key;
    logic              req_art;
    // low word of a doubleword load
    logic [word_w-1:0] low_half;
    logic [addr_w-1:0] ram_offset;
    logic              beat_high;
    logic              in_beat;
    logic              accept;
    logic              is_double;
    logic [data_w-1:0] result;

    // new requests only taken while idle so busy pulses drop
    assign accept    = (state == st_idle) && (read_en || write_en);
    assign is_double = req_ram && (req_type == ls_d);

    // one ram beat per st_low or st_high
    assign ram_offset = req_addr - ram_base;
    assign beat_high  = (state == st_high);
    assign in_beat    = (state == st_low) || beat_high;
    assign ram_index  = ram_offset[ram_idx_w+1:2] + {{(ram_idx_w-1){1'b0}}, beat_high};
    assign ram_shift  = ram_offset[1:0];
    assign ram_type   = req_type;
    assign ram_re     = in_beat && req_ram && req_read;
    assign ram_we     = in_beat && req_ram && !req_read;

    // byte lanes picked by size and offset
    always_comb begin
        case (req_type[1:0])
            2'd0:    ram_lane_mask = 4'b0001 << ram_shift;
            2'd1:    ram_lane_mask = 4'b0011 << ram_shift;
            default: ram_lane_mask = 4'b1111;
        endcase
    end

    // store data moved up into its lanes and the upper half sent on the second beat
    assign ram_wdata = beat_high ? req_data[data_w-1:word_w]
                                 : req_data[word_w-1:0] << {ram_shift, 3'b000};

    // unmapped reads return zero
    always_comb begin
        if (is_double) begin
            result = {ram_rdata[word_w-1:0], low_half};
        end else if (req_ram) begin
            result = ram_rdata;
        end else if (req_key) begin
            result = {{(data_w-8){1'b0}}, key_byte};
        end else begin
            result = '0;
        end
    end

    // access FSM and done flags
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state         <= st_idle;
            settled       <= 1'b0;
            read_done     <= 1'b1;
            write_done    <= 1'b1;
            art_wr_strobe <= 1'b0;
        end else begin
            art_wr_strobe <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        state      <= st_low;
                        read_done  <= !read_en;
                        write_done <= read_en;
                    end
                end
                st_low: begin
                    // console write goes out as a one-cycle strobe
                    art_wr_strobe <= req_art && !req_read;
                    state         <= is_double ? st_high : st_finish;
                end
                st_high: begin
                    state <= st_finish;
                end
                st_finish: begin
                    // first cycle captures data and the second raises done
                    settled <= !settled;
                    if (settled) begin
                        state      <= st_idle;
                        read_done  <= 1'b1;
                        write_done <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // request and data registers
    always_ff @(posedge CLOCK_50) begin
        if (accept) begin
            req_addr <= address;
            req_data <= write_data;
            req_type <= ls_type_e'(ls_type);
            req_read <= read_en;
            req_ram  <= (address >= ram_base) && (address < ram_base + ram_words * 4);
            req_key  <= (address == key_addr);
            req_art  <= (address == art_addr);
        end
        // low beat data is held while the high beat reads
        if (state == st_high) begin
            low_half <= ram_rdata[word_w-1:0];
        end
        if (state == st_low) begin
            art_byte <= req_data[7:0];
        end
        if (state == st_finish && !settled && req_read) begin
            read_data <= result;
        end
    end

endmodule

// ==== source/ram_bank.sv ====
`timescale 1ns/100ps

module ram_bank
    import soc_bus_pkg::*;
(
    input  logic                 CLOCK_50,
    input  logic [ram_idx_w-1:0] ram_index,
    input  logic [word_w/8-1:0]  ram_lane_mask,
    input  logic [word_w-1:0]    ram_wdata,
    input  logic                 ram_we,
    input  logic                 ram_re,
    input  logic [1:0]           ram_shift,
    input  ls_type_e             ram_type,
    output logic [data_w-1:0]    ram_rdata
);

    // word storage, little-endian lanes
    logic [word_w-1:0] mem [ram_words];
    logic [word_w-1:0] shifted;
    logic [data_w-1:0] extended;

    // addressed byte moved down to lane 0
    assign shifted = mem[ram_index] >> {ram_shift, 3'b000};

    // sign or zero extension by load type
    always_comb begin
        case (ram_type)
            ls_b: begin
                extended = {{(data_w-8){shifted[7]}}, shifted[7:0]};
            end
            ls_bu: begin
                extended = {{(data_w-8){1'b0}}, shifted[7:0]};
            end
            ls_h: begin
                extended = {{(data_w-16){shifted[15]}}, shifted[15:0]};
            end
            ls_hu: begin
                extended = {{(data_w-16){1'b0}}, shifted[15:0]};
            end
            ls_w: begin
                extended = {{(data_w-word_w){shifted[word_w-1]}}, shifted};
            end
            // raw word for unsigned word loads and doubleword beats
            default: begin
                extended = {{(data_w-word_w){1'b0}}, shifted};
            end
        endcase
    end

    // per-lane writes
    always_ff @(posedge CLOCK_50) begin
        for (int i = 0; i < word_w / 8; i++) begin
            if (ram_we && ram_lane_mask[i]) begin
                mem[ram_index][8*i +: 8] <= ram_wdata[8*i +: 8];
            end
        end
    end

    // registered read, holds until the next read beat
    always_ff @(posedge CLOCK_50) begin
        if (ram_re) begin
            ram_rdata <= extended;
        end
    end

endmodule

// ==== source/key_irq_unit.sv ====
`timescale 1ns/100ps

module key_irq_unit (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    // decoded keyboard
    input  logic       key_valid,
    input  logic [7:0] key_ascii,
    input  logic       irq_ack,
    // console write from the bus
    input  logic       art_wr_strobe,
    input  logic [7:0] art_byte,
    output logic [7:0] key_byte,
    output logic       irq,
    output logic       uart_valid,
    output logic [7:0] uart_data
);

    logic key_valid_q;
    logic new_key;

    // rising edge of key_valid, zero bytes ignored
    assign new_key = key_valid && !key_valid_q && (key_ascii != 8'd0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_valid_q <= 1'b0;
            key_byte    <= 8'd0;
            irq         <= 1'b0;
            uart_valid  <= 1'b0;
        end else begin
            key_valid_q <= key_valid;
            uart_valid  <= art_wr_strobe;
            if (new_key) begin
                key_byte <= key_ascii;
            end
            // a fresh key beats the ack in the same cycle
            if (new_key) begin
                irq <= 1'b1;
            end else if (irq_ack) begin
                irq <= 1'b0;
            end
        end
    end

    // console byte, held until the next write
    always_ff @(posedge CLOCK_50) begin
        if (art_wr_strobe) begin
            uart_data <= art_byte;
        end
    end

endmodule

// ==== source/soc_bus_top.sv ====
`timescale 1ns/100ps

module soc_bus_top
    import soc_bus_pkg::*;
(
    input  logic              CLOCK_50,
    input  logic              KEY0,
    // processor bus
    input  logic              read_en,
    input  logic              write_en,
    input  logic [addr_w-1:0] address,
    input  logic [data_w-1:0] write_data,
    input  logic [2:0]        ls_type,
    output logic              read_done,
    output logic              write_done,
    output logic [data_w-1:0] read_data,
    // decoded keyboard
    input  logic              key_valid,
    input  logic [7:0]        key_ascii,
    input  logic              irq_ack,
    output logic              irq,
    // console byte stream
    output logic              uart_valid,
    output logic [7:0]        uart_data
);

    // control to ram
    logic [ram_idx_w-1:0] ram_index;
    logic [word_w/8-1:0]  ram_lane_mask;
    logic [word_w-1:0]    ram_wdata;
    logic                 ram_we;
    logic                 ram_re;
    logic [1:0]           ram_shift;
    ls_type_e             ram_type;
    logic [data_w-1:0]    ram_rdata;

    // control to keyboard / console
    logic                 art_wr_strobe;
    logic [7:0]           art_byte;
    logic [7:0]           key_byte;

    bus_control u_bus_control (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .read_en       (read_en),
        .write_en      (write_en),
        .address       (address),
        .write_data    (write_data),
        .ls_type       (ls_type),
        .ram_rdata     (ram_rdata),
        .key_byte      (key_byte),
        .read_done     (read_done),
        .write_done    (write_done),
        .read_data     (read_data),
        .ram_index     (ram_index),
        .ram_lane_mask (ram_lane_mask),
        .ram_wdata     (ram_wdata),
        .ram_we        (ram_we),
        .ram_re        (ram_re),
        .ram_shift     (ram_shift),
        .ram_type      (ram_type),
        .art_wr_strobe (art_wr_strobe),
        .art_byte      (art_byte)
    );

    ram_bank u_ram_bank (
        .CLOCK_50      (CLOCK_50),
        .ram_index     (ram_index),
        .ram_lane_mask (ram_lane_mask),
        .ram_wdata     (ram_wdata),
        .ram_we        (ram_we),
        .ram_re        (ram_re),
        .ram_shift     (ram_shift),
        .ram_type      (ram_type),
        .ram_rdata     (ram_rdata)
    );

    key_irq_unit u_key_irq_unit (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .key_valid     (key_valid),
        .key_ascii     (key_ascii),
        .irq_ack       (irq_ack),
        .art_wr_strobe (art_wr_strobe),
        .art_byte      (art_byte),
        .key_byte      (key_byte),
        .irq           (irq),
        .uart_valid    (uart_valid),
        .uart_data     (uart_data)
    );

endmodule

// ==== tests/clock_gen.sv ====
`timescale 1ns/100ps

module clock_gen (
    output logic CLOCK_50,
    output logic KEY0
);

    // 100 ns period
    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;
    end

    // reset low for the first 4 cycles
    initial begin
        KEY0 = 1'b0;
        repeat (4) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
    end

endmodule

// ==== tests/bus_checker.sv ====
`timescale 1ns/100ps

module bus_checker
    import soc_bus_pkg::*;
(
    input  logic              CLOCK_50,
    // requests as the DUT samples them
    input  logic              read_en,
    input  logic              write_en,
    input  logic [addr_w-1:0] address,
    input  logic [2:0]        ls_type,
    input  logic              read_done,
    input  logic              write_done,
    input  logic [data_w-1:0] read_data,
    input  logic              irq,
    input  logic              uart_valid,
    input  logic [7:0]        uart_data,
    // expectations from the stimulus loop
    input  logic              check_read,
    input  logic [data_w-1:0] exp_read,
    input  logic              check_irq,
    input  logic              exp_irq,
    input  logic [7:0]        exp_uart,
    input  logic              check_uart_count,
    input  int                exp_uart_count,
    output int                errors,
    output int                uart_count
);

    // read_done one edge back
    logic done_q = 1'b1;
    // access in flight and cycles since its sampling edge
    logic busy = 1'b0;
    logic first_edge;
    logic read_req;
    int   busy_cycles;
    int   exp_cycles;

    initial begin
        errors     = 0;
        uart_count = 0;
    end

    always @(posedge CLOCK_50) begin
        done_q <= read_done;
        if (read_en === 1'b1 || write_en === 1'b1) begin
            busy        <= 1'b1;
            first_edge  <= 1'b1;
            read_req    <= read_en;
            busy_cycles <= 0;
            // ram doublewords take one extra beat
            if (ls_type == ls_d && address >= ram_base
                    && address - ram_base < 16'd1024) begin
                exp_cycles <= 4;
            end else begin
                exp_cycles <= 3;
            end
        end else if (busy) begin
            first_edge <= 1'b0;
            // matching done drops the cycle after the pulse
            if (first_edge && read_req && read_done !== 1'b0) begin
                $display("Fail at %0t: read_done expected 0, seen %b", $time, read_done);
                errors++;
            end
            if (first_edge && !read_req && write_done !== 1'b0) begin
                $display("Fail at %0t: write_done expected 0, seen %b", $time, write_done);
                errors++;
            end
            if (!first_edge && read_done === 1'b1 && write_done === 1'b1) begin
                busy <= 1'b0;
                if (busy_cycles != exp_cycles) begin
                    $display("Fail at %0t: %s rise after cycles expected %0d, seen %0d",
                             $time, read_req ? "read_done" : "write_done",
                             exp_cycles, busy_cycles);
                    errors++;
                end
            end else begin
                busy_cycles <= busy_cycles + 1;
            end
        end
        // read_data is valid once done is back high
        if (check_read && read_done === 1'b1 && done_q === 1'b0) begin
            if (read_data !== exp_read) begin
                $display("Fail at %0t: read_data expected %h, seen %h",
                         $time, exp_read, read_data);
                errors++;
            end
        end
        // one strobe per console write carrying its low byte
        if (uart_valid === 1'b1) begin
            uart_count++;
            if (uart_data !== exp_uart) begin
                $display("Fail at %0t: uart_data expected %h, seen %h",
                         $time, exp_uart, uart_data);
                errors++;
            end
        end
        if (check_irq && irq !== exp_irq) begin
            $display("Fail at %0t: irq expected %b, seen %b", $time, exp_irq, irq);
            errors++;
        end
        // strobe total against the console writes in the table
        if (check_uart_count && uart_count != exp_uart_count) begin
            $display("Fail at %0t: uart_valid pulses expected %0d, seen %0d",
                     $time, exp_uart_count, uart_count);
            errors++;
        end
    end

endmodule

// ==== tests/tb_soc_bus.sv ====
`timescale 1ns/100ps

module tb_soc_bus
    import soc_bus_pkg::*;
();

    typedef enum logic [1:0] {op_read, op_write, op_key, op_ack} op_e;
    // one table row, exp_val bit 0 is the irq level for keyboard rows
    typedef struct packed {
        op_e               op;
        logic [addr_w-1:0] addr;
        ls_type_e          ls;
        logic [data_w-1:0] wdata;
        logic [data_w-1:0] exp_val;
    } entry_t;

    logic              CLOCK_50;
    logic              KEY0;
    logic              read_en;
    logic              write_en;
    logic              read_done;
    logic              write_done;
    logic [addr_w-1:0] address;
    logic [data_w-1:0] write_data;
    logic [data_w-1:0] read_data;
    logic [2:0]        ls_type;
    logic              key_valid;
    logic [7:0]        key_ascii;
    logic              irq_ack;
    logic              irq;
    logic              uart_valid;
    logic [7:0]        uart_data;
    // checker side
    logic              check_read;
    logic [data_w-1:0] exp_read;
    logic              check_irq;
    logic              exp_irq;
    logic [7:0]        exp_uart;
    logic              check_uart_count;
    int                exp_uart_count = 0;
    int                errors;
    int                uart_count;
    // run limit
    int                cycles = 0;
    int                timeout_limit;
    logic [31:0]       rng_state = 32'd81;
    entry_t            tab[$];

    clock_gen   u_clock_gen (.*);
    soc_bus_top UUT (.*);
    bus_checker u_checker (.*);

    // 32-bit xorshift
    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic add_entry(input op_e op, input logic [addr_w-1:0] addr,
                             input ls_type_e ls, input logic [data_w-1:0] wdata,
                             input logic [data_w-1:0] exp_val);
        tab.push_back({op, addr, ls, wdata, exp_val});
        if (op == op_write && addr == art_addr) begin
            exp_uart_count++;
        end
    endtask

    task automatic build_table();
        logic [31:0]       r;
        logic [31:0]       first_word;
        logic [addr_w-1:0] a;
        // little-endian lanes of the byte test word
        logic [31:0]       lanes;
        lanes = 32'h44C3_2281;
        // word roundtrip, first word forced negative
        for (int i = 0; i < 3; i++) begin
            r = xorshift32();
            if (i == 0) begin
                r[31]      = 1'b1;
                first_word = r;
            end
            a = ram_base + 16'(i * 'h1FC);
            add_entry(op_write, a, ls_w, {xorshift32(), r}, '0);
            add_entry(op_read, a, ls_w, '0, {{32{r[31]}}, r});
            add_entry(op_read, a, ls_wu, '0, {32'd0, r});
        end
        // one byte per lane, junk above the byte
        for (int j = 0; j < 4; j++) begin
            add_entry(op_write, 16'h1100 + 16'(j), ls_b,
                      {{56{1'b1}}, lanes[8*j +: 8]}, '0);
        end
        add_entry(op_read, 16'h1100, ls_b, '0, {{56{lanes[7]}}, lanes[7:0]});
        add_entry(op_read, 16'h1100, ls_bu, '0, {56'd0, lanes[7:0]});
        add_entry(op_read, 16'h1102, ls_b, '0, {{56{lanes[23]}}, lanes[23:16]});
        add_entry(op_read, 16'h1103, ls_bu, '0, {56'd0, lanes[31:24]});
        add_entry(op_read, 16'h1100, ls_w, '0, {{32{lanes[31]}}, lanes});
        // halfword into the upper lanes of a known word
        add_entry(op_write, 16'h1104, ls_w, 64'h1234, '0);
        add_entry(op_write, 16'h1106, ls_h, 64'h5555_BEEF, '0);
        add_entry(op_read, 16'h1106, ls_h, '0, 64'hFFFF_FFFF_FFFF_BEEF);
        add_entry(op_read, 16'h1106, ls_hu, '0, 64'hBEEF);
        add_entry(op_read, 16'h1104, ls_wu, '0, 64'hBEEF_1234);
        // doubleword, low word first
        add_entry(op_write, 16'h1200, ls_d, 64'h8765_4321_0FED_CBA9, '0);
        add_entry(op_read, 16'h1200, ls_d, '0, 64'h8765_4321_0FED_CBA9);
        add_entry(op_read, 16'h1200, ls_wu, '0, 64'h0FED_CBA9);
        add_entry(op_read, 16'h1204, ls_wu, '0, 64'h8765_4321);
        // keyboard
        add_entry(op_key, '0, ls_b, 64'h41, 64'd1);
        add_entry(op_read, key_addr, ls_bu, '0, 64'h41);
        add_entry(op_ack, '0, ls_b, '0, 64'd0);
        add_entry(op_key, '0, ls_b, 64'h00, 64'd0);
        // console
        add_entry(op_write, art_addr, ls_b, 64'h1234_565A, '0);
        add_entry(op_write, art_addr, ls_b, 64'hFFFF_FFA7, '0);
        // unmapped, index bits would alias the first RAM word
        add_entry(op_read, 16'h3000, ls_d, '0, '0);
        add_entry(op_write, 16'h3000, ls_w, 64'hDEAD_BEEF, '0);
        add_entry(op_read, ram_base, ls_wu, '0, {32'd0, first_word});
    endtask

    // one pulse, then wait for both done flags
    task automatic bus_access(input entry_t e);
        @(posedge CLOCK_50);
        address    <= e.addr;
        ls_type    <= e.ls;
        write_data <= e.wdata;
        exp_read   <= e.exp_val;
        exp_uart   <= e.wdata[7:0];
        check_read <= (e.op == op_read);
        read_en    <= (e.op == op_read);
        write_en   <= (e.op == op_write);
        @(posedge CLOCK_50);
        read_en  <= 1'b0;
        write_en <= 1'b0;
        @(posedge CLOCK_50);
        while (!(read_done && write_done)) begin
            @(posedge CLOCK_50);
        end
    endtask

    task automatic request_irq_check(input logic irq_level);
        exp_irq   <= irq_level;
        check_irq <= 1'b1;
        @(posedge CLOCK_50);
        check_irq <= 1'b0;
    endtask

    // key_valid high 2 cycles, low 2 cycles
    task automatic key_press(input logic [7:0] ascii, input logic irq_level);
        @(posedge CLOCK_50);
        key_ascii <= ascii;
        key_valid <= 1'b1;
        repeat (2) @(posedge CLOCK_50);
        key_valid <= 1'b0;
        repeat (2) @(posedge CLOCK_50);
        request_irq_check(irq_level);
    endtask

    task automatic ack_irq(input logic irq_level);
        @(posedge CLOCK_50);
        irq_ack <= 1'b1;
        @(posedge CLOCK_50);
        irq_ack <= 1'b0;
        request_irq_check(irq_level);
    endtask

    initial begin
        entry_t e;
        read_en          = 1'b0;
        write_en         = 1'b0;
        address          = '0;
        write_data       = '0;
        ls_type          = '0;
        key_valid        = 1'b0;
        key_ascii        = '0;
        irq_ack          = 1'b0;
        check_read       = 1'b0;
        exp_read         = '0;
        check_irq        = 1'b0;
        exp_irq          = 1'b0;
        exp_uart         = '0;
        check_uart_count = 1'b0;
        build_table();
        timeout_limit = tab.size() * 10 + 50;
        @(posedge KEY0);
        for (int i = 0; i < tab.size(); i++) begin
            e = tab[i];
            case (e.op)
                op_key:  key_press(e.wdata[7:0], e.exp_val[0]);
                op_ack:  ack_irq(e.exp_val[0]);
                default: bus_access(e);
            endcase
        end
        // console pulse total
        @(posedge CLOCK_50);
        check_uart_count <= 1'b1;
        @(posedge CLOCK_50);
        check_uart_count <= 1'b0;
        @(posedge CLOCK_50);
        $display("%0d errors, %0d console pulses", errors, uart_count);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // limit scales with the table length
    always @(posedge CLOCK_50) begin
        cycles <= cycles + 1;
        if (cycles > timeout_limit) begin
            $display("timeout: the table did not finish within %0d cycles", timeout_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

endmodule

// ==== src.f ====
source/soc_bus_pkg.sv
source/bus_control.sv
source/ram_bank.sv
source/key_irq_unit.sv
source/soc_bus_top.sv
tests/clock_gen.sv
tests/bus_checker.sv
tests/tb_soc_bus.sv
